//--- alu_bitcount.f
+incdir+hw
hw/drac_pkg.sv
hw/riscv_pkg.sv
hw/alu_count_zeros_lzc32.sv
hw/alu_count_zeros.sv
hw/alu_cpop.sv
hw/alu_bitcount_result.sv
hw/alu_bitcount.sv
sim/alu_bitcount_sva.sv
sim/tb_alu_bitcount.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the bit-count testbench with verilator and runs it
# exit status is zero only when the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f alu_bitcount.f \
    --top-module tb_alu_bitcount \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_alu_bitcount 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_alu_bitcount.sv
////////////////////////////////////////
// table-driven testbench for the bit-count unit
// checks each op one cycle after its strobe
////////////////////////////////////////
`timescale 1ns/1ns

module tb_alu_bitcount
    import riscv_pkg::*;
();

    localparam int NUM_ROWS       = 48;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS + RESET_CYCLES + 20;

    // dut pins
    logic        clk_i;
    logic        reset_i;
    logic        valid_i;
    instr_type_t instr_type_i;
    logic [63:0] data_rs1_i;
    logic        valid_o;
    logic [63:0] result_o;

    // stimulus table with expected counts
    logic        row_valid [NUM_ROWS];
    instr_type_t row_op    [NUM_ROWS];
    logic [63:0] row_data  [NUM_ROWS];
    logic [63:0] row_exp   [NUM_ROWS];
    int          n_rows = 0;

    // what the outputs should show at the next check
    logic        exp_valid;
    logic [63:0] exp_result;
    int          cycle_count = 0;

    alu_bitcount u_alu_bitcount (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .instr_type_i (instr_type_i),
        .data_rs1_i   (data_rs1_i),
        .valid_o      (valid_o),
        .result_o     (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // hard stop if the run stalls
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "simulation timed out");
        end
    end

    // bit-by-bit model of the zbb count rules
    function automatic logic [63:0] ref_count(instr_type_t op, logic [63:0] data);
        int width;
        int cnt;
        bit hit;
        width = (op == CLZW || op == CTZW || op == CPOPW) ? 32 : 64;
        cnt = 0;
        hit = 1'b0;
        case (op)
            CLZ, CLZW: begin
                // scan from the top of the operand
                for (int i = width - 1; i >= 0; i--) begin
                    if (data[i]) begin
                        hit = 1'b1;
                    end else if (!hit) begin
                        cnt++;
                    end
                end
            end
            CTZ, CTZW: begin
                for (int i = 0; i < width; i++) begin
                    if (data[i]) begin
                        hit = 1'b1;
                    end else if (!hit) begin
                        cnt++;
                    end
                end
            end
            CPOP, CPOPW: begin
                for (int i = 0; i < width; i++) begin
                    if (data[i]) begin
                        cnt++;
                    end
                end
            end
            // not a count op
            default: cnt = 0;
        endcase
        return 64'(cnt);
    endfunction

    task automatic add_row(logic valid, instr_type_t op, logic [63:0] data);
        row_valid[n_rows] = valid;
        row_op[n_rows]    = op;
        row_data[n_rows]  = data;
        row_exp[n_rows]   = ref_count(op, data);
        n_rows++;
    endtask

    task automatic build_table();
        instr_type_t op_pool [10];
        logic [3:0]  pick;
        op_pool = '{CLZ, CLZW, CTZ, CTZW, CPOP, CPOPW, ADD, SUB, AND_OP, OR_OP};
        // full-width zero counts, edges and single bits
        add_row(1'b1, CLZ, 64'h0);
        add_row(1'b1, CTZ, 64'h0);
        add_row(1'b1, CLZ, '1);
        add_row(1'b1, CTZ, '1);
        add_row(1'b1, CLZ, 64'h1);
        add_row(1'b1, CTZ, 64'h1);
        add_row(1'b1, CLZ, 64'h8000_0000_0000_0000);
        add_row(1'b1, CTZ, 64'h8000_0000_0000_0000);
        add_row(1'b1, CLZ, 64'h0000_0000_8000_0000);
        add_row(1'b1, CTZ, 64'h0000_0001_0000_0000);
        add_row(1'b1, CLZ, 64'h0000_0001_0000_0000);
        add_row(1'b1, CTZ, 64'h0000_0000_8000_0000);
        // word forms with junk in the upper half
        add_row(1'b1, CLZW, 64'hdead_beef_0000_0001);
        add_row(1'b1, CTZW, 64'hdead_beef_0000_0001);
        add_row(1'b1, CLZW, 64'hffff_ffff_0000_0000);
        add_row(1'b1, CTZW, 64'hffff_ffff_0000_0000);
        add_row(1'b1, CLZW, 64'h0000_0000_8000_0000);
        add_row(1'b1, CTZW, 64'h1234_5678_8000_0000);
        // population counts
        add_row(1'b1, CPOP, '1);
        add_row(1'b1, CPOPW, '1);
        add_row(1'b1, CPOP, 64'h0);
        add_row(1'b1, CPOP, 64'h8000_0000_0000_0000);
        add_row(1'b1, CPOPW, 64'h0000_0001_0000_0000);
        // idle cycle, result must hold
        add_row(1'b0, CPOP, '1);
        // other alu ops read as zero
        add_row(1'b1, ADD, '1);
        add_row(1'b1, SUB, 64'h0123_4567_89ab_cdef);
        add_row(1'b1, AND_OP, 64'h1);
        add_row(1'b1, OR_OP, 64'h8000_0000_0000_0000);
        add_row(1'b0, CLZ, 64'h0);
        add_row(1'b1, CLZ, 64'h0000_0000_0000_00f0);
        // rest is random, mostly strobed
        while (n_rows < NUM_ROWS) begin
            pick = 4'($urandom_range(9, 0));
            add_row(($urandom_range(3, 0) != 0), op_pool[pick], {$urandom, $urandom});
        end
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_outputs();
        check_value("valid_o", 64'(valid_o), 64'(exp_valid));
        check_value("result_o", result_o, exp_result);
    endtask

    task automatic apply_row(int idx);
        valid_i      = row_valid[idx];
        instr_type_i = row_op[idx];
        data_rs1_i   = row_data[idx];
    endtask

    initial begin
        reset_i      = 1'b1;
        valid_i      = 1'b0;
        instr_type_i = ADD;
        data_rs1_i   = '0;
        void'($urandom(32'h9308_4533));
        build_table();

        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;

        // first check sees the post-reset state
        exp_valid  = 1'b0;
        exp_result = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk_i);
            check_outputs();
            apply_row(i);
            exp_valid = row_valid[i];
            if (row_valid[i]) begin
                exp_result = row_exp[i];
            end
        end

        // drain the last op, then one idle cycle
        @(negedge clk_i);
        check_outputs();
        valid_i   = 1'b0;
        exp_valid = 1'b0;
        @(negedge clk_i);
        check_outputs();

        $display("No errors");
        $finish;
    end

endmodule

//--- sim/alu_bitcount_sva.sv
////////////////////////////////////////
// port assertions, bound onto the top level
////////////////////////////////////////
`timescale 1ns/1ns
`include "bitcount_cfg.svh"

module alu_bitcount_sva (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  valid_i,
    input logic                  valid_o,
    input logic [`DRAC_XLEN-1:0] result_o
);

    // held in reset means no output strobe
    assert property (@(posedge clk_i) reset_i |=> !valid_o)
        else $error("valid_o high after a reset cycle");

    // exactly one cycle of latency
    assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> (valid_o == $past(valid_i)))
        else $error("valid_o does not follow valid_i by one cycle");

    // a count never goes past the operand width
    assert property (@(posedge clk_i) disable iff (reset_i)
        result_o <= `DRAC_XLEN'(`DRAC_XLEN))
        else $error("result_o larger than the operand width");

endmodule

bind alu_bitcount alu_bitcount_sva u_sva (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .result_o (result_o)
);

//--- hw/alu_bitcount.sv
////////////////////////////////////////
// zbb bit-count unit top, one cycle latency
// one op per cycle on valid_i, no back-pressure
////////////////////////////////////////
`timescale 1ns/1ns

module alu_bitcount
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        valid_i,
    input  instr_type_t instr_type_i,
    input  bus64_t      data_rs1_i,
    output logic        valid_o,
    output bus64_t      result_o
);

    // counter outputs into the result stage
    count_t zeros;
    count_t pop;

    // leading and trailing zeros
    alu_count_zeros u_count_zeros (
        .data_rs1_i   (data_rs1_i),
        .instr_type_i (instr_type_i),
        .zeros_o      (zeros)
    );

    // set bits, side by side with the zero counter
    alu_cpop u_cpop (
        .data_rs1_i   (data_rs1_i),
        .instr_type_i (instr_type_i),
        .pop_o        (pop)
    );

    // only state in the unit
    alu_bitcount_result u_result (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .instr_type_i (instr_type_i),
        .zeros_i      (zeros),
        .pop_i        (pop),
        .valid_o      (valid_o),
        .result_o     (result_o)
    );

endmodule

//--- hw/alu_bitcount_result.sv
////////////////////////////////////////
// picks the count by opcode, single register stage
////////////////////////////////////////
`timescale 1ns/1ns

module alu_bitcount_result
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        valid_i,
    input  instr_type_t instr_type_i,
    input  count_t      zeros_i,
    input  count_t      pop_i,
    output logic        valid_o,
    output bus64_t      result_o
);

    // which counter the opcode belongs to
    typedef enum logic [1:0] {
        CLASS_ZEROS,
        CLASS_POP,
        CLASS_NONE
    } count_class_t;

    count_class_t op_class;
    bus64_t       result_d;

    always_comb begin
        case (instr_type_i)
            CLZ, CLZW, CTZ, CTZW: op_class = CLASS_ZEROS;
            CPOP, CPOPW:          op_class = CLASS_POP;
            default:              op_class = CLASS_NONE;
        endcase
    end

    // zero-extend the chosen count
    always_comb begin
        case (op_class)
            CLASS_ZEROS: result_d = bus64_t'(zeros_i);
            CLASS_POP:   result_d = bus64_t'(pop_i);
            // other alu ops are not ours
            default:     result_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            // valid follows the strobe every cycle
            valid_o <= valid_i;
            // result holds between strobes
            if (valid_i) begin
                result_o <= result_d;
            end
        end
    end

endmodule

//--- hw/alu_cpop.sv
////////////////////////////////////////
// set-bit count, adder tree, cpop and cpopw
////////////////////////////////////////
`timescale 1ns/1ns
`include "bitcount_cfg.svh"

module alu_cpop
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  bus64_t      data_rs1_i,
    input  instr_type_t instr_type_i,
    output count_t      pop_o
);

    // operand with upper half masked for word form
    bus64_t     data_m;
    // partial sums, each level doubles the span
    logic [1:0] sum2 [32];
    logic [2:0] sum3 [16];
    logic [3:0] sum4 [8];
    logic [4:0] sum5 [4];
    logic [5:0] sum6 [2];

    always_comb begin
        data_m = data_rs1_i;
        if (instr_type_i == CPOPW) begin
            data_m[`DRAC_XLEN-1:`DRAC_HALF] = '0;
        end
    end

    always_comb begin
        // bit pairs
        for (int k = 0; k < 32; k++) begin
            sum2[k] = {1'b0, data_m[2*k]} + {1'b0, data_m[2*k+1]};
        end
        for (int k = 0; k < 16; k++) begin
            sum3[k] = {1'b0, sum2[2*k]} + {1'b0, sum2[2*k+1]};
        end
        for (int k = 0; k < 8; k++) begin
            sum4[k] = {1'b0, sum3[2*k]} + {1'b0, sum3[2*k+1]};
        end
        for (int k = 0; k < 4; k++) begin
            sum5[k] = {1'b0, sum4[2*k]} + {1'b0, sum4[2*k+1]};
        end
        // one sum per 32-bit half
        for (int k = 0; k < 2; k++) begin
            sum6[k] = {1'b0, sum5[2*k]} + {1'b0, sum5[2*k+1]};
        end
    end

    // final add, 7 bits holds 64
    assign pop_o = {1'b0, sum6[0]} + {1'b0, sum6[1]};

endmodule

//--- hw/alu_count_zeros.sv
////////////////////////////////////////
// clz / ctz for full and word operands
// pure combinational, feeds the result stage
////////////////////////////////////////
`timescale 1ns/1ns
`include "bitcount_cfg.svh"

module alu_count_zeros
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  bus64_t      data_rs1_i,
    input  instr_type_t instr_type_i,
    output count_t      zeros_o
);

    // operand after reversal or masking
    bus64_t     data_to_calc;
    // per-half lzc outputs
    logic       q_high;
    logic       q_low;
    logic [4:0] y_high;
    logic [4:0] y_low;
    // 64-bit count before word rebase
    count_t     merged;
    logic       is_word;

    // trailing counts become leading counts on the reversed value
    always_comb begin
        case (instr_type_i)
            CTZ: begin
                for (int i = 0; i < `DRAC_XLEN; i++) begin
                    data_to_calc[i] = data_rs1_i[`DRAC_XLEN-1-i];
                end
            end
            CTZW: begin
                // reverse the low word only
                for (int i = 0; i < `DRAC_HALF; i++) begin
                    data_to_calc[i] = data_rs1_i[`DRAC_HALF-1-i];
                end
                data_to_calc[`DRAC_XLEN-1:`DRAC_HALF] = '0;
            end
            CLZW: begin
                data_to_calc[`DRAC_HALF-1:0] = data_rs1_i[`DRAC_HALF-1:0];
                data_to_calc[`DRAC_XLEN-1:`DRAC_HALF] = '0;
            end
            default: begin
                // clz, and anything else passes straight through
                data_to_calc = data_rs1_i;
            end
        endcase
    end

    alu_count_zeros_lzc32 lzc_high (
        .data_i (data_to_calc[`DRAC_XLEN-1:`DRAC_HALF]),
        .q_o    (q_high),
        .y_o    (y_high)
    );

    alu_count_zeros_lzc32 lzc_low (
        .data_i (data_to_calc[`DRAC_HALF-1:0]),
        .q_o    (q_low),
        .y_o    (y_low)
    );

    assign is_word = (instr_type_i == CLZW) || (instr_type_i == CTZW);

    // combine the halves
    always_comb begin
        if (q_high && q_low) begin
            merged = count_t'(`DRAC_XLEN);
        end else if (q_high) begin
            // high half empty, keep counting into the low one
            merged = count_t'(`DRAC_HALF) + count_t'(y_low);
        end else begin
            merged = count_t'(y_high);
        end
    end

    // word forms always see an empty upper half, so drop the 32
    assign zeros_o = is_word ? (merged - count_t'(`DRAC_HALF)) : merged;

endmodule

//--- hw/alu_count_zeros_lzc32.sv
////////////////////////////////////////
// 32-bit leading-zero counter, nibble tree
////////////////////////////////////////
`timescale 1ns/1ns

module alu_count_zeros_lzc32
    import drac_pkg::*;
(
    input  bus32_t     data_i,
    output logic       q_o,
    output logic [4:0] y_o
);

    // per-nibble zero flags and counts
    logic [7:0] nib_z;
    logic [1:0] nib_c [8];
    // byte level
    logic [3:0] byte_z;
    logic [2:0] byte_c [4];
    // halfword level
    logic [1:0] half_z;
    logic [3:0] half_c [2];
    // whole word count before masking
    logic [4:0] word_c;

    always_comb begin
        // leaf stage, priority inside each nibble
        for (int k = 0; k < 8; k++) begin
            nib_z[k] = (data_i[4*k +: 4] == 4'd0);
            nib_c[k] = data_i[4*k+3] ? 2'd0 :
                       data_i[4*k+2] ? 2'd1 :
                       data_i[4*k+1] ? 2'd2 : 2'd3;
        end

        // upper nibble all zero means skip 4 and count the lower one
        for (int k = 0; k < 4; k++) begin
            byte_z[k] = nib_z[2*k+1] & nib_z[2*k];
            byte_c[k] = nib_z[2*k+1] ? {1'b1, nib_c[2*k]} : {1'b0, nib_c[2*k+1]};
        end

        // same merge one level up
        for (int k = 0; k < 2; k++) begin
            half_z[k] = byte_z[2*k+1] & byte_z[2*k];
            half_c[k] = byte_z[2*k+1] ? {1'b1, byte_c[2*k]} : {1'b0, byte_c[2*k+1]};
        end

        // root
        word_c = half_z[1] ? {1'b1, half_c[0]} : {1'b0, half_c[1]};
    end

    // all-zero flag, caller adds the 32
    assign q_o = half_z[1] & half_z[0];
    // tree saturates at 31 on zero input, force it clean
    assign y_o = q_o ? 5'd0 : word_c;

endmodule

//--- hw/riscv_pkg.sv
////////////////////////////////////////
// alu instruction types seen by the bit-count slice
////////////////////////////////////////

package riscv_pkg;

    // opcodes as presented by decode
    // only the zbb counts are handled here, the rest give zero
    typedef enum logic [4:0] {
        // plain integer ops
        ADD    = 5'd0,
        SUB    = 5'd1,
        AND_OP = 5'd2,
        OR_OP  = 5'd3,
        // leading zeros, full and word
        CLZ    = 5'd8,
        CLZW   = 5'd9,
        // trailing zeros, full and word
        CTZ    = 5'd10,
        CTZW   = 5'd11,
        // set-bit count, full and word
        CPOP   = 5'd12,
        CPOPW  = 5'd13
    } instr_type_t;

endpackage

//--- hw/drac_pkg.sv
////////////////////////////////////////
// datapath types for the bit-count slice
// import in any block carrying operands or counts
////////////////////////////////////////
`include "bitcount_cfg.svh"

package drac_pkg;

    // full operand and result word
    typedef logic [`DRAC_XLEN-1:0] bus64_t;

    // one half of the operand
    // word ops only look at the low one
    typedef logic [`DRAC_HALF-1:0] bus32_t;

    // count result, wide enough for 64
    typedef logic [`DRAC_CNT_W-1:0] count_t;

endpackage

//--- hw/bitcount_cfg.svh
////////////////////////////////////////
// widths for the zbb bit-count datapath
// include wherever operand or count sizes are needed
////////////////////////////////////////
`ifndef BITCOUNT_CFG_SVH
`define BITCOUNT_CFG_SVH

// full operand width, rv64
`define DRAC_XLEN 64
// word operand width, also one lzc slice
`define DRAC_HALF 32
// count values run 0 to 64
`define DRAC_CNT_W 7

`endif
